// ==== common/conv_front_pkg.sv ====
`default_nettype none

package conv_front_pkg;

    //////////////////////////////////////////////////////////////////////
    // Pixel and kernel geometry
    //////////////////////////////////////////////////////////////////////

    // Width of one pixel in bits
    localparam int PIX_W = 8;

    // Kernel side, also the number of line buffers
    localparam int KSIZE = 3;

    // Bits in one full window
    localparam int WIN_W = KSIZE * KSIZE * PIX_W;

    //////////////////////////////////////////////////////////////////////
    // Types
    //////////////////////////////////////////////////////////////////////

    typedef logic [PIX_W-1:0] pixel_t;

    // Row or column index, images up to 256 x 256
    typedef logic [7:0] coord_t;

    // Selects one of the line buffers
    typedef logic [1:0] buf_sel_t;

    // Pixel (i, j) at byte i*KSIZE + j, row 0 on top, column 0 on the left
    typedef logic [WIN_W-1:0] window_t;

endpackage

`default_nettype wire

// ==== common/line_buf_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface line_buf_if import conv_front_pkg::*; ();

    // Single-cycle strobes from the router
    logic   wr_en;
    logic   rd_en;

    // Shared column address for write and read
    coord_t addr;
    pixel_t wr_data;

    // Valid the cycle after rd_en, held until the next one
    pixel_t rd_data;

    modport router (
        output wr_en,
        output rd_en,
        output addr,
        output wr_data
    );

    modport buffer (
        input  wr_en,
        input  rd_en,
        input  addr,
        input  wr_data,
        output rd_data
    );

endinterface

`default_nettype wire

// ==== common/window_tap_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface window_tap_if import conv_front_pkg::*; ();

    // One-cycle strobe, aligned with line buffer read data
    logic     tap_valid;
    pixel_t   tap_pixel;

    // Raster position of the tapped pixel
    coord_t   tap_row;
    coord_t   tap_col;

    // Buffer holding the current row
    buf_sel_t tap_wsel;

    modport router (
        output tap_valid,
        output tap_pixel,
        output tap_row,
        output tap_col,
        output tap_wsel
    );

    modport assembler (
        input  tap_valid,
        input  tap_pixel,
        input  tap_row,
        input  tap_col,
        input  tap_wsel
    );

endinterface

`default_nettype wire

// ==== verilog/row_router.sv ====
`timescale 1ns/100ps
`default_nettype none

module row_router import conv_front_pkg::*; #(
    parameter int IMG_W = 8,
    parameter int IMG_H = 6
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         pix_valid,
    input  pixel_t       pix_data,
    line_buf_if.router   bufs [KSIZE],
    window_tap_if.router tap
);

    localparam coord_t   LAST_COL = coord_t'(IMG_W - 1);
    localparam coord_t   LAST_ROW = coord_t'(IMG_H - 1);
    localparam buf_sel_t LAST_SEL = buf_sel_t'(KSIZE - 1);

    coord_t   col_cnt;
    coord_t   row_cnt;
    buf_sel_t wsel;

    //////////////////////////////////////////////////////////////////////
    // Raster position and buffer rotation
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            col_cnt <= '0;
            row_cnt <= '0;
            wsel    <= '0;
        end else if (pix_valid) begin
            if (col_cnt == LAST_COL) begin
                col_cnt <= '0;
                row_cnt <= (row_cnt == LAST_ROW) ? '0 : row_cnt + 1'b1;
                // Next row goes to the next buffer, frame edges included
                wsel    <= (wsel == LAST_SEL) ? '0 : wsel + 1'b1;
            end else begin
                col_cnt <= col_cnt + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Buffer strobes
    //////////////////////////////////////////////////////////////////////

    // Write goes to one buffer, all three read the same column.
    // The buffer being written returns its stale row, which is ignored.
    for (genvar i = 0; i < KSIZE; i++) begin : g_buf
        assign bufs[i].wr_en   = pix_valid && (wsel == buf_sel_t'(i));
        assign bufs[i].rd_en   = pix_valid;
        assign bufs[i].addr    = col_cnt;
        assign bufs[i].wr_data = pix_data;
    end

    //////////////////////////////////////////////////////////////////////
    // Tap register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            tap.tap_valid <= 1'b0;
        end else begin
            tap.tap_valid <= pix_valid;
        end
    end

    // Lines up with the buffer read data one cycle later
    always_ff @(posedge clk) begin
        if (pix_valid) begin
            tap.tap_pixel <= pix_data;
            tap.tap_row   <= row_cnt;
            tap.tap_col   <= col_cnt;
            tap.tap_wsel  <= wsel;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/line_buffer.sv ====
`timescale 1ns/100ps
`default_nettype none

module line_buffer import conv_front_pkg::*; #(
    parameter int IMG_W = 8
) (
    input  logic       clk,
    line_buf_if.buffer port
);

    // Address bits needed to cover one row
    localparam int AW = (IMG_W > 1) ? $clog2(IMG_W) : 1;

    // One image row
    pixel_t mem [IMG_W];

    //////////////////////////////////////////////////////////////////////
    // Storage with a registered read port
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (port.wr_en) begin
            mem[port.addr[AW-1:0]] <= port.wr_data;
        end
    end

    // Read-first, like a block RAM; data holds until the next rd_en
    always_ff @(posedge clk) begin
        if (port.rd_en) begin
            port.rd_data <= mem[port.addr[AW-1:0]];
        end
    end

endmodule

`default_nettype wire

// ==== window/window_assembler.sv ====
`timescale 1ns/100ps
`default_nettype none

module window_assembler import conv_front_pkg::*; #(
    parameter int IMG_H = 6,
    parameter int IMG_W = 8
) (
    input  logic                   clk,
    input  logic                   rst,
    input  pixel_t                 buf_data [KSIZE],
    window_tap_if.assembler        tap,
    output logic                   win_valid,
    output window_t                win_data,
    output coord_t                 win_row,
    output coord_t                 win_col,
    output logic                   frame_done
);

    localparam coord_t EDGE     = coord_t'(KSIZE - 1);
    localparam coord_t LAST_ROW = coord_t'(IMG_H - 1);
    localparam coord_t LAST_COL = coord_t'(IMG_W - 1);

    // Buffer index for each older row, top first
    buf_sel_t row_sel [KSIZE-1];

    // Incoming column, top to bottom
    pixel_t   col_new [KSIZE];

    // Sliding window, column 0 is the oldest (left)
    pixel_t   win_cols [KSIZE][KSIZE];

    //////////////////////////////////////////////////////////////////////
    // Row reordering
    //////////////////////////////////////////////////////////////////////

    // Row minus k lives in buffer (wsel - k) mod 3, i.e. wsel + 3 - k
    always_comb begin
        for (int i = 0; i < KSIZE - 1; i++) begin
            row_sel[i] = buf_sel_t'((int'(tap.tap_wsel) + i + 1) % KSIZE);
            col_new[i] = buf_data[row_sel[i]];
        end
        // Bottom row comes straight from the tap
        col_new[KSIZE-1] = tap.tap_pixel;
    end

    //////////////////////////////////////////////////////////////////////
    // Column shift register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (tap.tap_valid) begin
            for (int j = 0; j < KSIZE - 1; j++) begin
                win_cols[j] <= win_cols[j+1];
            end
            win_cols[KSIZE-1] <= col_new;
        end
    end

    // Pixel (i, j) goes to byte i*KSIZE + j
    for (genvar i = 0; i < KSIZE; i++) begin : g_row
        for (genvar j = 0; j < KSIZE; j++) begin : g_col
            assign win_data[(i*KSIZE+j)*PIX_W +: PIX_W] = win_cols[j][i];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Window and frame-end strobes
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            win_valid  <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            // Needs KSIZE rows and columns in hand
            win_valid  <= tap.tap_valid && (tap.tap_row >= EDGE) && (tap.tap_col >= EDGE);
            frame_done <= tap.tap_valid && (tap.tap_row == LAST_ROW)
                          && (tap.tap_col == LAST_COL);
        end
    end

    // Top-left corner of the window
    always_ff @(posedge clk) begin
        if (tap.tap_valid) begin
            win_row <= tap.tap_row - EDGE;
            win_col <= tap.tap_col - EDGE;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/conv_front_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module conv_front_top import conv_front_pkg::*; #(
    parameter int IMG_W = 8,
    parameter int IMG_H = 6
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    pix_valid,
    input  pixel_t  pix_data,
    output logic    win_valid,
    output window_t win_data,
    output coord_t  win_row,
    output coord_t  win_col,
    output logic    frame_done
);

    // Router to line buffer links
    line_buf_if   bufs [KSIZE] ();

    // Registered pixel tap for the assembler
    window_tap_if tap ();

    // Read data of every buffer
    pixel_t       buf_data [KSIZE];

    //////////////////////////////////////////////////////////////////////
    // Datapath
    //////////////////////////////////////////////////////////////////////

    row_router #(
        .IMG_W (IMG_W),
        .IMG_H (IMG_H)
    ) router_i (
        .clk       (clk),
        .rst       (rst),
        .pix_valid (pix_valid),
        .pix_data  (pix_data),
        .bufs      (bufs),
        .tap       (tap)
    );

    for (genvar i = 0; i < KSIZE; i++) begin : g_line
        line_buffer #(
            .IMG_W (IMG_W)
        ) line_buffer_i (
            .clk  (clk),
            .port (bufs[i])
        );

        assign buf_data[i] = bufs[i].rd_data;
    end

    window_assembler #(
        .IMG_H (IMG_H),
        .IMG_W (IMG_W)
    ) assembler_i (
        .clk        (clk),
        .rst        (rst),
        .buf_data   (buf_data),
        .tap        (tap),
        .win_valid  (win_valid),
        .win_data   (win_data),
        .win_row    (win_row),
        .win_col    (win_col),
        .frame_done (frame_done)
    );

endmodule

`default_nettype wire

// ==== verif/conv_front_assertions.sv ====
`timescale 1ns/100ps
`default_nettype none

module conv_front_assertions import conv_front_pkg::*; #(
    parameter int IMG_W = 8
) (
    input logic   clk,
    input logic   rst,
    input logic   pix_valid,
    input logic   win_valid,
    input coord_t win_col
);

    // Outputs cleared by reset
    assert property (@(posedge clk) rst |=> !win_valid)
        else $error("win_valid high after a reset cycle");

    // Two-cycle latency from strobe to window
    assert property (@(posedge clk) disable iff (rst) win_valid |-> $past(pix_valid, 2))
        else $error("win_valid without a strobe two cycles earlier");

    // Window never runs past the right edge
    assert property (@(posedge clk) disable iff (rst)
                     win_valid |-> (win_col <= coord_t'(IMG_W - KSIZE)))
        else $error("win_col beyond the last window column");

endmodule

bind conv_front_top conv_front_assertions #(.IMG_W(IMG_W)) assertions_i (
    .clk       (clk),
    .rst       (rst),
    .pix_valid (pix_valid),
    .win_valid (win_valid),
    .win_col   (win_col)
);

`default_nettype wire

// ==== verif/conv_front_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module conv_front_tb import conv_front_pkg::*; ();

    localparam int IMG_W        = 8;
    localparam int IMG_H        = 6;
    localparam int N_PIX        = IMG_W * IMG_H;
    localparam int N_WIN        = (IMG_H - 2) * (IMG_W - 2);
    localparam int PERIOD       = 8;
    localparam int RESET_CYCLES = 8;
    localparam int MAX_GAP      = 5;
    // Five frames are sent over the whole run
    localparam int TOTAL_PIX    = 5 * N_PIX;
    localparam int WATCHDOG_NS  = 2 * TOTAL_PIX * (MAX_GAP + 1) * PERIOD + RESET_CYCLES * PERIOD;

    typedef struct packed {
        window_t data;
        coord_t  row;
        coord_t  col;
    } exp_win_t;

    logic    clk;
    logic    rst;
    logic    pix_valid;
    pixel_t  pix_data;
    logic    win_valid;
    window_t win_data;
    coord_t  win_row;
    coord_t  win_col;
    logic    frame_done;

    pixel_t   frames [2][N_PIX];
    exp_win_t exp_q [$];
    int       win_cnt = 0;
    int       done_cnt = 0;

    conv_front_top #(.IMG_W(IMG_W), .IMG_H(IMG_H)) dut_i (
        .clk(clk), .rst(rst), .pix_valid(pix_valid), .pix_data(pix_data),
        .win_valid(win_valid), .win_data(win_data), .win_row(win_row),
        .win_col(win_col), .frame_done(frame_done)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Checking helpers
    //////////////////////////////////////////////////////////////////////

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("STATUS: FAIL");
        $fatal(1, "Simulation stopped on first error");
    endtask

    task automatic check_value(input string name, input window_t got, input window_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("FAIL time %0t: %s got %0h expected %0h",
                                    $time, name, got, exp));
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus and reference model
    //////////////////////////////////////////////////////////////////////

    task automatic fill_random(input int idx);
        for (int p = 0; p < N_PIX; p++) begin
            frames[idx][p] = pixel_t'($urandom);
        end
    endtask

    // Every top-left corner in raster order
    // Pixel (i, j) sits at byte i*3 + j
    task automatic push_expected(input int idx);
        exp_win_t e;
        for (int r = 0; r <= IMG_H - KSIZE; r++) begin
            for (int c = 0; c <= IMG_W - KSIZE; c++) begin
                e.data = '0;
                for (int i = 0; i < KSIZE; i++) begin
                    for (int j = 0; j < KSIZE; j++) begin
                        e.data[(i*KSIZE+j)*PIX_W +: PIX_W] = frames[idx][(r+i)*IMG_W + c + j];
                    end
                end
                e.row = coord_t'(r);
                e.col = coord_t'(c);
                exp_q.push_back(e);
            end
        end
    endtask

    task automatic drive_pixels(input int idx, input int first, input int count,
                                input int max_gap);
        int gap;
        @(negedge clk);
        for (int p = first; p < first + count; p++) begin
            gap = int'($urandom_range(max_gap, 0));
            pix_valid = 1'b1;
            pix_data  = frames[idx][p];
            @(negedge clk);
            pix_valid = 1'b0;
            repeat (gap) @(negedge clk);
        end
    endtask

    // Returns once every expected window has been seen
    task automatic wait_drain();
        while (exp_q.size() != 0) @(posedge clk);
    endtask

    // One expected window per win_valid, frame_done pulses counted
    always @(negedge clk) begin : monitor
        exp_win_t e;
        if (!rst && win_valid) begin
            if (exp_q.size() == 0) begin
                stop_on_error("Window output appeared with no window expected");
            end else begin
                e = exp_q.pop_front();
                win_cnt++;
                check_value("win_data", win_data, e.data);
                check_value("win_row", window_t'(win_row), window_t'(e.row));
                check_value("win_col", window_t'(win_col), window_t'(e.col));
            end
        end
        if (!rst && frame_done) begin
            done_cnt++;
            check_value("win_valid at frame_done", window_t'(win_valid), window_t'(1'b1));
            check_value("win_row at frame_done", window_t'(win_row), window_t'(IMG_H - 3));
            check_value("win_col at frame_done", window_t'(win_col), window_t'(IMG_W - 3));
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic idle_after_reset();
        repeat (16) begin
            @(negedge clk);
            check_value("win_valid", window_t'(win_valid), '0);
            check_value("frame_done", window_t'(frame_done), '0);
        end
    endtask

    // Covers both the back-to-back frame and its replay with random gaps
    task automatic run_one_frame(input bit new_data, input int max_gap);
        int w0;
        int d0;
        w0 = win_cnt;
        d0 = done_cnt;
        if (new_data) fill_random(0);
        push_expected(0);
        drive_pixels(0, 0, N_PIX, max_gap);
        wait_drain();
        check_value("window count", window_t'(win_cnt - w0), window_t'(N_WIN));
        check_value("frame_done count", window_t'(done_cnt - d0), window_t'(1));
    endtask

    task automatic two_frames_back_to_back();
        int w0;
        int d0;
        w0 = win_cnt;
        d0 = done_cnt;
        fill_random(0);
        fill_random(1);
        push_expected(0);
        push_expected(1);
        drive_pixels(0, 0, N_PIX, 0);
        drive_pixels(1, 0, N_PIX, 0);
        wait_drain();
        check_value("window count", window_t'(win_cnt - w0), window_t'(2 * N_WIN));
        check_value("frame_done count", window_t'(done_cnt - d0), window_t'(2));
    endtask

    // Last pixel of the frame arrives alone after a pause
    task automatic single_strobe_latency();
        fill_random(0);
        push_expected(0);
        drive_pixels(0, 0, N_PIX - 1, 0);
        repeat (4) @(negedge clk);
        pix_valid = 1'b1;
        pix_data  = frames[0][N_PIX-1];
        @(negedge clk);
        pix_valid = 1'b0;
        check_value("win_valid one cycle after strobe", window_t'(win_valid), '0);
        @(negedge clk);
        check_value("win_valid two cycles after strobe", window_t'(win_valid), window_t'(1'b1));
        check_value("frame_done two cycles after strobe", window_t'(frame_done), window_t'(1'b1));
        @(negedge clk);
        check_value("win_valid three cycles after strobe", window_t'(win_valid), '0);
        wait_drain();
    endtask

    initial begin
        rst       = 1'b1;
        pix_valid = 1'b0;
        pix_data  = '0;
        void'($urandom(68));
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        idle_after_reset();
        run_one_frame(1'b1, 0);
        run_one_frame(1'b0, MAX_GAP);
        two_frames_back_to_back();
        single_strobe_latency();
        if (exp_q.size() == 0 && done_cnt == 5) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            stop_on_error("Run ended with windows missing or a wrong frame_done count");
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        stop_on_error($sformatf("Watchdog expired after %0d ns, DUT stopped responding",
                                WATCHDOG_NS));
    end

endmodule

`default_nettype wire

// ==== compile.f ====
common/conv_front_pkg.sv
common/line_buf_if.sv
common/window_tap_if.sv
verilog/row_router.sv
verilog/line_buffer.sv
window/window_assembler.sv
verilog/conv_front_top.sv
verif/conv_front_assertions.sv
verif/conv_front_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the convolution front-end testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module conv_front_tb \
    -Mdir obj_dir -o conv_front_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "Verilator build failed, see build.log"
    exit 1
fi

./obj_dir/conv_front_sim > sim.log 2>&1
sim_status=$?

if grep -q "STATUS: FAIL" sim.log; then
    echo "Simulation reported a failure, see sim.log"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status, see sim.log"
    exit 1
fi

echo "Simulation passed"
exit 0
